//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "^Test completed successfully$$" $(LOG) && echo "PASS" || \
		(echo "FAIL: see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- axil_pkg.sv
package axil_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [1:0]        resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // manager to subordinate
    typedef struct packed {
        addr_t awaddr;
        logic  awvalid;
        data_t wdata;
        strb_t wstrb;
        logic  wvalid;
        logic  bready;
        addr_t araddr;
        logic  arvalid;
        logic  rready;
    } axil_req_t;

    // subordinate to manager
    typedef struct packed {
        logic  awready;
        logic  wready;
        resp_t bresp;
        logic  bvalid;
        logic  arready;
        data_t rdata;
        resp_t rresp;
        logic  rvalid;
    } axil_rsp_t;

    // register map
    localparam addr_t REG_CONTROL  = 8'h00;
    localparam addr_t REG_PRIV     = 8'h04;
    localparam addr_t REG_DISPLAY  = 8'h08;
    localparam addr_t REG_CYCLE_LO = 8'h0C;
    localparam addr_t REG_CYCLE_HI = 8'h10;

    // CONTROL bits, same position on read and write
    localparam int CTRL_INIT_BIT = 0;
    localparam int CTRL_LOAD_BIT = 1;
    localparam int CTRL_STOP_BIT = 2;

endpackage

//--- panel_pkg.sv
package panel_pkg;

    typedef logic [3:0] nibble_t;
    typedef logic [7:0] seg_t;
    typedef logic [7:0] anode_t;
    typedef logic [2:0] digit_idx_t;

    // bit 2 blue, bit 1 green, bit 0 red
    typedef logic [2:0] rgb_t;

    // RISC-V privilege encodings, 2 is reserved
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_e;

    typedef struct packed {
        logic        init_done;
        logic        loading;
        priv_e       priv;
        logic [31:0] disp_value;
    } panel_ctrl_t;

    localparam rgb_t RGB_OFF   = 3'b000;
    localparam rgb_t RGB_BLUE  = 3'b100;
    localparam rgb_t RGB_GREEN = 3'b010;
    localparam rgb_t RGB_RED   = 3'b001;

    // segment order is dp a b c d e f g, active high
    localparam seg_t GLYPH_BLANK = 8'b0000_0000;
    localparam seg_t GLYPH_DP    = 8'b1000_0000;
    localparam seg_t GLYPH_UC_A  = 8'b0111_0111;
    localparam seg_t GLYPH_LC_A  = 8'b0111_1101;
    localparam seg_t GLYPH_C     = 8'b0000_1101;
    localparam seg_t GLYPH_D     = 8'b0011_1101;
    localparam seg_t GLYPH_G     = 8'b0111_1011;
    localparam seg_t GLYPH_H     = 8'b0001_0111;
    localparam seg_t GLYPH_I     = 8'b0001_0000;
    localparam seg_t GLYPH_L     = 8'b0000_1110;
    localparam seg_t GLYPH_N     = 8'b0001_0101;
    localparam seg_t GLYPH_O     = 8'b0001_1101;
    localparam seg_t GLYPH_P     = 8'b0110_0111;
    localparam seg_t GLYPH_R     = 8'b0000_0101;

    // hex digits, entry F on the left
    localparam seg_t [15:0] HEX_GLYPH = {
        8'b0100_0111, 8'b0100_1111, 8'b0011_1101, 8'b0100_1110,
        8'b0001_1111, 8'b0111_0111, 8'b0111_1011, 8'b0111_1111,
        8'b0111_0000, 8'b0101_1111, 8'b0101_1011, 8'b0011_0011,
        8'b0111_1001, 8'b0110_1101, 8'b0011_0000, 8'b0111_1110
    };

    // "ArchProc", digit 7 on the left
    localparam seg_t [7:0] IDLE_BANNER = {
        GLYPH_UC_A, GLYPH_R, GLYPH_C, GLYPH_H,
        GLYPH_P, GLYPH_R, GLYPH_O, GLYPH_C
    };

    // entry 15 on the left, seven blanks lead in at the low end
    localparam seg_t [15:0] LOAD_STRIP = {
        GLYPH_DP, GLYPH_DP, GLYPH_G, GLYPH_N, GLYPH_I, GLYPH_D, GLYPH_LC_A, GLYPH_O,
        GLYPH_L, {7{GLYPH_BLANK}}
    };

endpackage

//--- panel_regs.sv
`timescale 1ns/100ps

module panel_regs
    import axil_pkg::*;
    import panel_pkg::*;
#(
    parameter int unsigned HEARTBEAT_DIV = 32000000
) (
    input  logic        CORE_CLK,
    input  logic        arst_n,
    input  axil_req_t   axi_req,
    output axil_rsp_t   axi_rsp,
    output panel_ctrl_t panel_ctrl,
    output logic        heartbeat
);

    localparam int HB_W = $clog2(HEARTBEAT_DIV + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRESP,
        ST_RRESP
    } bus_state_e;

    bus_state_e      state;
    panel_ctrl_t     ctrl_q;
    logic            stopped;
    logic [63:0]     cycle_cnt;
    logic [HB_W-1:0] hb_cnt;
    logic            wr_go;
    logic            rd_go;
    logic            wr_ok;
    resp_t           bresp_q;
    resp_t           rresp_q;
    data_t           rdata_q;
    data_t           rd_mux;
    resp_t           rd_resp;

    // one transaction in flight, a write wins a tie with a read
    assign wr_go = (state == ST_IDLE) && axi_req.awvalid && axi_req.wvalid;
    assign rd_go = (state == ST_IDLE) && axi_req.arvalid && !wr_go;

    assign wr_ok = (axi_req.awaddr == REG_CONTROL) ||
                   (axi_req.awaddr == REG_PRIV) ||
                   (axi_req.awaddr == REG_DISPLAY);

    always_ff @(posedge CORE_CLK or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            ctrl_q  <= '0;
            stopped <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (wr_go) begin
                        state <= ST_WRESP;
                    end else if (rd_go) begin
                        state <= ST_RRESP;
                    end
                end
                ST_WRESP: begin
                    if (axi_req.bready) begin
                        state <= ST_IDLE;
                    end
                end
                ST_RRESP: begin
                    if (axi_req.rready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase

            if (wr_go) begin
                case (axi_req.awaddr)
                    REG_CONTROL: begin
                        if (axi_req.wstrb[0]) begin
                            // init ends any load in progress
                            if (axi_req.wdata[CTRL_INIT_BIT]) begin
                                ctrl_q.init_done <= 1'b1;
                                ctrl_q.loading   <= 1'b0;
                            end else if (axi_req.wdata[CTRL_LOAD_BIT] && !ctrl_q.init_done) begin
                                ctrl_q.loading <= 1'b1;
                            end
                            if (axi_req.wdata[CTRL_STOP_BIT]) begin
                                stopped <= 1'b1;
                            end
                        end
                    end
                    REG_PRIV: begin
                        if (axi_req.wstrb[0]) begin
                            ctrl_q.priv <= priv_e'(axi_req.wdata[1:0]);
                        end
                    end
                    REG_DISPLAY: begin
                        for (int b = 0; b < STRB_W; b++) begin
                            if (axi_req.wstrb[b]) begin
                                ctrl_q.disp_value[b*8 +: 8] <= axi_req.wdata[b*8 +: 8];
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // core cycles, frozen for good once stopped
    always_ff @(posedge CORE_CLK or negedge arst_n) begin
        if (!arst_n) begin
            cycle_cnt <= '0;
        end else if (ctrl_q.init_done && !stopped) begin
            cycle_cnt <= cycle_cnt + 64'd1;
        end
    end

    always_ff @(posedge CORE_CLK or negedge arst_n) begin
        if (!arst_n) begin
            hb_cnt    <= '0;
            heartbeat <= 1'b0;
        end else if (hb_cnt == HB_W'(HEARTBEAT_DIV - 1)) begin
            hb_cnt    <= '0;
            heartbeat <= ~heartbeat;
        end else begin
            hb_cnt <= hb_cnt + 1'b1;
        end
    end

    always_comb begin
        rd_mux  = '0;
        rd_resp = RESP_OKAY;
        case (axi_req.araddr)
            REG_CONTROL: begin
                rd_mux[CTRL_INIT_BIT] = ctrl_q.init_done;
                rd_mux[CTRL_LOAD_BIT] = ctrl_q.loading;
                rd_mux[CTRL_STOP_BIT] = stopped;
            end
            REG_PRIV:     rd_mux = {30'd0, ctrl_q.priv};
            REG_DISPLAY:  rd_mux = ctrl_q.disp_value;
            REG_CYCLE_LO: rd_mux = cycle_cnt[31:0];
            REG_CYCLE_HI: rd_mux = cycle_cnt[63:32];
            default:      rd_resp = RESP_SLVERR;
        endcase
    end

    // response payload, captured at the handshake
    always_ff @(posedge CORE_CLK) begin
        if (wr_go) begin
            bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_go) begin
            rdata_q <= rd_mux;
            rresp_q <= rd_resp;
        end
    end

    assign axi_rsp.awready = wr_go;
    assign axi_rsp.wready  = wr_go;
    assign axi_rsp.bvalid  = (state == ST_WRESP);
    assign axi_rsp.bresp   = bresp_q;
    assign axi_rsp.arready = rd_go;
    assign axi_rsp.rvalid  = (state == ST_RRESP);
    assign axi_rsp.rdata   = rdata_q;
    assign axi_rsp.rresp   = rresp_q;

    assign panel_ctrl = ctrl_q;

    // a response stays up and unchanged until the manager takes it
    bvalid_held: assert property (@(posedge CORE_CLK) disable iff (!arst_n)
        axi_rsp.bvalid && !axi_req.bready |=> axi_rsp.bvalid && $stable(axi_rsp.bresp));

    rvalid_held: assert property (@(posedge CORE_CLK) disable iff (!arst_n)
        axi_rsp.rvalid && !axi_req.rready
        |=> axi_rsp.rvalid && $stable(axi_rsp.rdata) && $stable(axi_rsp.rresp));

endmodule

//--- rgb_indicator.sv
`timescale 1ns/100ps

module rgb_indicator
    import panel_pkg::*;
#(
    parameter int unsigned PWM_BITS = 12
) (
    input  logic        CORE_CLK,
    input  logic        arst_n,
    input  panel_ctrl_t panel_ctrl,
    output rgb_t        rgb
);

    localparam int PH_W = PWM_BITS + 1;

    // per colour, index 0 red, 1 green, 2 blue
    localparam int unsigned PHASE_STEP [3] = '{5, 3, 2};
    localparam int unsigned PHASE_INIT [3] = '{1 << (PWM_BITS - 1), 1 << (PWM_BITS - 2), 0};

    logic [PWM_BITS-1:0] ramp;
    logic [PH_W-1:0]     phase [3];
    logic [3:0]          blink_cnt;
    rgb_t                pwm;
    rgb_t                priv_rgb;

    always_ff @(posedge CORE_CLK or negedge arst_n) begin
        if (!arst_n) begin
            ramp      <= '0;
            blink_cnt <= '0;
            for (int c = 0; c < 3; c++) begin
                phase[c] <= PH_W'(PHASE_INIT[c]);
            end
        end else begin
            ramp      <= ramp + 1'b1;
            blink_cnt <= blink_cnt + 4'd1;
            if (ramp == '0) begin
                for (int c = 0; c < 3; c++) begin
                    phase[c] <= phase[c] + PH_W'(PHASE_STEP[c]);
                end
            end
        end
    end

    // top phase bit picks the falling half of the triangle
    always_comb begin
        for (int c = 0; c < 3; c++) begin
            if (phase[c][PWM_BITS]) begin
                pwm[c] = (phase[c][PWM_BITS-1:0] < ramp);
            end else begin
                pwm[c] = (phase[c][PWM_BITS-1:0] >= ramp);
            end
        end
    end

    always_comb begin
        case (panel_ctrl.priv)
            PRIV_U:  priv_rgb = RGB_BLUE;
            PRIV_S:  priv_rgb = RGB_GREEN;
            PRIV_M:  priv_rgb = RGB_RED;
            default: priv_rgb = RGB_OFF;
        endcase
    end

    // short flash, one clock out of sixteen
    always_ff @(posedge CORE_CLK or negedge arst_n) begin
        if (!arst_n) begin
            rgb <= RGB_OFF;
        end else if (panel_ctrl.loading) begin
            rgb <= pwm;
        end else if (panel_ctrl.init_done && blink_cnt == 4'd0) begin
            rgb <= priv_rgb;
        end else begin
            rgb <= RGB_OFF;
        end
    end

endmodule

//--- seg7_scan.sv
`timescale 1ns/100ps

module seg7_scan
    import panel_pkg::*;
#(
    parameter int unsigned SCAN_DIV       = 16000,
    parameter int unsigned LOAD_STEP_BITS = 25
) (
    input  logic        CORE_CLK,
    input  logic        arst_n,
    input  panel_ctrl_t panel_ctrl,
    output seg_t        seg_n,
    output anode_t      an_n
);

    localparam int SCAN_W = $clog2(SCAN_DIV + 1);

    logic [SCAN_W-1:0]         scan_cnt;
    logic                      scan_tick;
    digit_idx_t                digit;
    digit_idx_t                digit_nxt;
    logic [LOAD_STEP_BITS-1:0] step_cnt;
    logic [3:0]                strip_pos;
    logic [3:0]                strip_idx;
    nibble_t                   hex_digit;
    seg_t                      glyph;

    assign scan_tick = (scan_cnt == SCAN_W'(SCAN_DIV - 1));
    assign digit_nxt = digit + 3'd1;

    // digit starts at 7 so the first tick lights digit 0
    always_ff @(posedge CORE_CLK or negedge arst_n) begin
        if (!arst_n) begin
            scan_cnt <= '0;
            digit    <= 3'd7;
            an_n     <= '1;
        end else if (scan_tick) begin
            scan_cnt <= '0;
            digit    <= digit_nxt;
            an_n     <= ~(anode_t'(1) << digit_nxt);
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // strip position moves once per full wrap of step_cnt
    always_ff @(posedge CORE_CLK or negedge arst_n) begin
        if (!arst_n) begin
            step_cnt  <= '0;
            strip_pos <= '0;
        end else if (panel_ctrl.loading) begin
            step_cnt <= step_cnt + 1'b1;
            if (&step_cnt) begin
                strip_pos <= strip_pos + 4'd1;
            end
        end
    end

    // digit 7 is leftmost, so it gets the oldest strip entry
    assign strip_idx = strip_pos + 4'd7 - {1'b0, digit};
    assign hex_digit = panel_ctrl.disp_value[{digit, 2'b00} +: 4];

    always_comb begin
        if (panel_ctrl.loading) begin
            glyph = LOAD_STRIP[strip_idx];
        end else if (!panel_ctrl.init_done) begin
            glyph = IDLE_BANNER[digit];
        end else begin
            glyph = HEX_GLYPH[hex_digit];
        end
    end

    // cathodes are active low on the board
    always_ff @(posedge CORE_CLK or negedge arst_n) begin
        if (!arst_n) begin
            seg_n <= '1;
        end else begin
            seg_n <= ~glyph;
        end
    end

    an_one_digit: assert property (@(posedge CORE_CLK) disable iff (!arst_n)
        $onehot0(~an_n));

endmodule

//--- status_panel_top.sv
`timescale 1ns/100ps

module status_panel_top
    import axil_pkg::*;
    import panel_pkg::*;
#(
    parameter int unsigned SCAN_DIV       = 16000,
    parameter int unsigned LOAD_STEP_BITS = 25,
    parameter int unsigned PWM_BITS       = 12,
    parameter int unsigned HEARTBEAT_DIV  = 32000000
) (
    input  logic      CORE_CLK,
    input  logic      arst_n,
    input  axil_req_t axi_req,
    output axil_rsp_t axi_rsp,
    output seg_t      seg_n,
    output anode_t    an_n,
    output rgb_t      rgb,
    output logic      heartbeat
);

    panel_ctrl_t panel_ctrl;

    panel_regs #(
        .HEARTBEAT_DIV (HEARTBEAT_DIV)
    ) regs0 (
        .CORE_CLK   (CORE_CLK),
        .arst_n     (arst_n),
        .axi_req    (axi_req),
        .axi_rsp    (axi_rsp),
        .panel_ctrl (panel_ctrl),
        .heartbeat  (heartbeat)
    );

    seg7_scan #(
        .SCAN_DIV       (SCAN_DIV),
        .LOAD_STEP_BITS (LOAD_STEP_BITS)
    ) scan0 (
        .CORE_CLK   (CORE_CLK),
        .arst_n     (arst_n),
        .panel_ctrl (panel_ctrl),
        .seg_n      (seg_n),
        .an_n       (an_n)
    );

    rgb_indicator #(
        .PWM_BITS (PWM_BITS)
    ) rgb0 (
        .CORE_CLK   (CORE_CLK),
        .arst_n     (arst_n),
        .panel_ctrl (panel_ctrl),
        .rgb        (rgb)
    );

endmodule

//--- tb.f
panel_pkg.sv
axil_pkg.sv
panel_regs.sv
seg7_scan.sv
rgb_indicator.sv
status_panel_top.sv
tb_clkgen.sv
tb_top.sv

//--- tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
    parameter int unsigned HALF_NS      = 10,
    parameter int unsigned RESET_CYCLES = 2
) (
    output logic CORE_CLK,
    output logic arst_n
);

    initial begin
        CORE_CLK = 1'b0;
        forever #(HALF_NS) CORE_CLK = ~CORE_CLK;
    end

    // release away from the clock edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge CORE_CLK);
        #2;
        arst_n = 1'b1;
    end

endmodule

//--- tb_top.sv
`timescale 1ns/100ps

module tb_top
    import axil_pkg::*;
    import panel_pkg::*;
();

    localparam int unsigned SCAN_DIV       = 4;
    localparam int unsigned LOAD_STEP_BITS = 3;
    localparam int unsigned PWM_BITS       = 4;
    localparam int unsigned HEARTBEAT_DIV  = 8;
    // tests take well under a thousand clocks
    localparam int unsigned MAX_CYCLES     = 20000;

    // colour bits ordered blue, green, red
    localparam rgb_t COLOUR_BLUE  = 3'b100;
    localparam rgb_t COLOUR_GREEN = 3'b010;
    localparam rgb_t COLOUR_RED   = 3'b001;

    logic        CORE_CLK;
    logic        arst_n;
    axil_req_t   req;
    axil_rsp_t   rsp;
    seg_t        seg_n;
    anode_t      an_n;
    rgb_t        rgb;
    logic        heartbeat;
    int unsigned cycle_cnt = 0;

    tb_clkgen #(
        .HALF_NS      (10),
        .RESET_CYCLES (2)
    ) clk0 (
        .CORE_CLK (CORE_CLK),
        .arst_n   (arst_n)
    );

    status_panel_top #(
        .SCAN_DIV       (SCAN_DIV),
        .LOAD_STEP_BITS (LOAD_STEP_BITS),
        .PWM_BITS       (PWM_BITS),
        .HEARTBEAT_DIV  (HEARTBEAT_DIV)
    ) dut0 (
        .CORE_CLK  (CORE_CLK),
        .arst_n    (arst_n),
        .axi_req   (req),
        .axi_rsp   (rsp),
        .seg_n     (seg_n),
        .an_n      (an_n),
        .rgb       (rgb),
        .heartbeat (heartbeat)
    );

    always @(posedge CORE_CLK) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: tests still running after %0d clock cycles", cycle_cnt);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR at time %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // inputs change 2 ns after the edge, outputs are settled there too
    task automatic next_cycle();
        @(posedge CORE_CLK);
        #2;
    endtask

    task automatic axil_write(input addr_t addr, input data_t data, input strb_t strb,
                              output resp_t resp);
        int unsigned delay;
        delay = $urandom % 4;
        req.awaddr  = addr;
        req.wdata   = data;
        req.wstrb   = strb;
        req.awvalid = 1'b1;
        req.wvalid  = 1'b1;
        do begin
            @(negedge CORE_CLK);
        end while (!(rsp.awready && rsp.wready));
        next_cycle();
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        check(rsp.bvalid, 1'b1, "bvalid one cycle after write handshake");
        repeat (delay) next_cycle();
        req.bready = 1'b1;
        @(negedge CORE_CLK);
        check(rsp.bvalid, 1'b1, "bvalid held until bready");
        resp = rsp.bresp;
        next_cycle();
        req.bready = 1'b0;
    endtask

    task automatic axil_read(input addr_t addr, output data_t data, output resp_t resp);
        int unsigned delay;
        delay = $urandom % 4;
        req.araddr  = addr;
        req.arvalid = 1'b1;
        do begin
            @(negedge CORE_CLK);
        end while (!rsp.arready);
        next_cycle();
        req.arvalid = 1'b0;
        check(rsp.rvalid, 1'b1, "rvalid one cycle after read handshake");
        repeat (delay) next_cycle();
        req.rready = 1'b1;
        @(negedge CORE_CLK);
        check(rsp.rvalid, 1'b1, "rvalid held until rready");
        data = rsp.rdata;
        resp = rsp.rresp;
        next_cycle();
        req.rready = 1'b0;
    endtask

    task automatic write_ok(input addr_t addr, input data_t data, input strb_t strb);
        resp_t resp;
        axil_write(addr, data, strb, resp);
        check(resp, RESP_OKAY, "write response");
    endtask

    task automatic read_expect(input addr_t addr, input data_t exp, input string what);
        data_t data;
        resp_t resp;
        axil_read(addr, data, resp);
        check(resp, RESP_OKAY, "read response");
        check(data, exp, what);
    endtask

    function automatic int lit_digit(input anode_t an);
        int idx;
        idx = -1;
        for (int i = 0; i < 8; i++) begin
            if (!an[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // mode 0 idle banner, 1 hex value, 2 loading strip on digit 0
    task automatic watch_digits(input int mode, input int cycles, input data_t value,
                                output logic [7:0] seen, output logic moved,
                                output logic rgb_lit);
        anode_t prev_an;
        int     held;
        int     d;
        seg_t   first_seg;
        logic   have_first;
        logic   in_strip;
        seen       = '0;
        moved      = 1'b0;
        rgb_lit    = 1'b0;
        have_first = 1'b0;
        held       = 0;
        prev_an    = 'x;
        repeat (cycles) begin
            next_cycle();
            if (rgb != 3'b000) begin
                rgb_lit = 1'b1;
            end
            held    = (an_n === prev_an) ? held + 1 : 1;
            prev_an = an_n;
            d       = lit_digit(an_n);
            // segments lag the anode by one clock
            if (held >= 2 && d >= 0) begin
                seen[d] = 1'b1;
                if (mode == 0) begin
                    check(seg_n, seg_t'(~IDLE_BANNER[d]), "idle banner glyph");
                end else if (mode == 1) begin
                    check(seg_n, seg_t'(~HEX_GLYPH[value[4*d +: 4]]), "hex digit glyph");
                end else if (d == 0) begin
                    in_strip = 1'b0;
                    for (int i = 0; i < 16; i++) begin
                        if (seg_n == seg_t'(~LOAD_STRIP[i])) begin
                            in_strip = 1'b1;
                        end
                    end
                    check(in_strip, 1'b1, "digit 0 shows a loading strip entry");
                    if (have_first && seg_n != first_seg) begin
                        moved = 1'b1;
                    end
                    if (!have_first) begin
                        first_seg  = seg_n;
                        have_first = 1'b1;
                    end
                end
            end
        end
    endtask

    initial begin
        resp_t      resp;
        data_t      a;
        data_t      b;
        data_t      value;
        logic [7:0] seen;
        logic       moved;
        logic       lit;
        int         lit_cnt;
        int         run;
        logic       hb_prev;
        priv_e      privs [3];
        rgb_t       colours [3];

        void'($urandom(32'h2e1f));
        req = '0;
        wait (arst_n);
        next_cycle();

        // register access and error responses
        write_ok(REG_DISPLAY, 32'hA5C3_0F96, 4'hF);
        write_ok(REG_DISPLAY, 32'h0000_5A00, 4'b0010);
        write_ok(REG_PRIV, 32'h1, 4'h1);
        read_expect(REG_DISPLAY, 32'hA5C3_5A96, "display readback with byte strobe");
        read_expect(REG_PRIV, 32'h1, "privilege readback");
        axil_write(REG_CYCLE_LO, 32'hFFFF_FFFF, 4'hF, resp);
        check(resp, RESP_SLVERR, "write to read-only cycle register");
        axil_read(8'h20, a, resp);
        check(resp, RESP_SLVERR, "unmapped read response");
        check(a, 32'h0, "unmapped read data");

        // idle banner
        watch_digits(0, 40, '0, seen, moved, lit);
        check(seen, 8'hFF, "every digit seen with the idle banner");

        // loading banner and breathing LED
        write_ok(REG_CONTROL, 32'h2, 4'h1);
        read_expect(REG_CONTROL, 32'h2, "control while loading");
        watch_digits(2, 200, '0, seen, moved, lit);
        check(seen[0], 1'b1, "digit 0 seen while loading");
        check(moved, 1'b1, "loading strip scrolls");
        check(lit, 1'b1, "rgb lit while loading");
        write_ok(REG_CONTROL, 32'h1, 4'h1);
        read_expect(REG_CONTROL, 32'h1, "control after init");

        // hex display of a random value
        value = $urandom;
        write_ok(REG_DISPLAY, value, 4'hF);
        read_expect(REG_DISPLAY, value, "random display readback");
        watch_digits(1, 40, value, seen, moved, lit);
        check(seen, 8'hFF, "every digit seen with the hex value");

        // cycle counter runs, then freezes after stop
        read_expect(REG_CONTROL, 32'h1, "control before stop");
        axil_read(REG_CYCLE_LO, a, resp);
        axil_read(REG_CYCLE_LO, b, resp);
        check(b > a, 1'b1, "cycle count increases while running");
        write_ok(REG_CONTROL, 32'h4, 4'h1);
        read_expect(REG_CONTROL, 32'h5, "control after stop");
        axil_read(REG_CYCLE_LO, a, resp);
        axil_read(REG_CYCLE_LO, b, resp);
        check(b, a, "cycle count frozen after stop");

        // privilege blink, one flash per sixteen clocks
        privs   = '{PRIV_U, PRIV_S, PRIV_M};
        colours = '{COLOUR_BLUE, COLOUR_GREEN, COLOUR_RED};
        for (int p = 0; p < 3; p++) begin
            write_ok(REG_PRIV, 32'(privs[p]), 4'h1);
            next_cycle();
            lit_cnt = 0;
            repeat (32) begin
                next_cycle();
                if (rgb != 3'b000) begin
                    lit_cnt++;
                    check(rgb, colours[p], "privilege colour");
                end
            end
            check(lit_cnt, 2, "blink count in 32 clocks");
        end

        // heartbeat never holds for 10 clocks
        run     = 0;
        hb_prev = heartbeat;
        repeat (40) begin
            next_cycle();
            run = (heartbeat === hb_prev) ? run + 1 : 1;
            hb_prev = heartbeat;
            check(run < 10, 1'b1, "heartbeat toggles within 10 clocks");
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule
